/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns --top-module wisc_cpu_tb \
	-f wisc_cpu.f -o sim_wisc_cpu || { echo "run_sim: build failed"; exit 1; }

sim_out=$(./obj_dir/sim_wisc_cpu 2>&1)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "Simulation PASSED" && exit 0 || exit 1

/* source/wisc_alu.sv */
`timescale 1ns/1ns

module wisc_alu (
	input  logic             clk,
	input  logic             arst_n_i,
	wisc_ctrl_if.alu         ctrl,
	input  wisc_pkg::word_t  a_i,
	input  wisc_pkg::word_t  b_i,
	output wisc_pkg::word_t  result_o,
	output wisc_pkg::word_t  addr_o,
	output wisc_pkg::flags_t flags_o
);

	wisc_pkg::word_t  opnd_b;
	wisc_pkg::word_t  sum;
	wisc_pkg::word_t  diff;
	wisc_pkg::word_t  red;
	wisc_pkg::word_t  paddsb;
	wisc_pkg::flags_t flags_q;
	logic [wisc_pkg::IMM_W-1:0]    shamt;
	logic [2*wisc_pkg::WORD_W-1:0] rot_wide;
	logic sum_ovf;
	logic diff_ovf;

	assign opnd_b   = ctrl.use_imm ? ctrl.imm : b_i;
	assign shamt    = opnd_b[wisc_pkg::IMM_W-1:0];
	assign sum      = a_i + opnd_b;
	assign diff     = a_i - opnd_b;
	assign sum_ovf  = (a_i[15] == opnd_b[15]) && (sum[15] != a_i[15]);
	assign diff_ovf = (a_i[15] != opnd_b[15]) && (diff[15] != a_i[15]);
	assign rot_wide = {a_i, a_i} >> shamt;

	// four signed bytes summed at full width.
	assign red = {{8{a_i[15]}}, a_i[15:8]} + {{8{a_i[7]}}, a_i[7:0]}
		+ {{8{opnd_b[15]}}, opnd_b[15:8]} + {{8{opnd_b[7]}}, opnd_b[7:0]};

	always_comb begin
		logic [4:0] nib_sum;
		for (int i = 0; i < 4; i++) begin
			nib_sum = {a_i[4*i+3], a_i[4*i +: 4]} + {opnd_b[4*i+3], opnd_b[4*i +: 4]};
			if (nib_sum[4] != nib_sum[3]) begin
				paddsb[4*i +: 4] = nib_sum[4] ? 4'h8 : 4'h7; // clamp to the signed nibble range.
			end else begin
				paddsb[4*i +: 4] = nib_sum[3:0];
			end
		end
	end

	always_comb begin
		case (ctrl.op)
			wisc_pkg::OP_SUB:    result_o = diff;
			wisc_pkg::OP_XOR:    result_o = a_i ^ opnd_b;
			wisc_pkg::OP_RED:    result_o = red;
			wisc_pkg::OP_SLL:    result_o = a_i << shamt;
			wisc_pkg::OP_SRA:    result_o = $signed(a_i) >>> shamt;
			wisc_pkg::OP_ROR:    result_o = rot_wide[wisc_pkg::WORD_W-1:0];
			wisc_pkg::OP_PADDSB: result_o = paddsb;
			default:             result_o = sum;
		endcase
	end

	// word address from a halfword offset.
	assign addr_o = {a_i[15:1], 1'b0} + {ctrl.imm[14:0], 1'b0};

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			flags_q <= '0;
		end else begin
			case (ctrl.op)
				wisc_pkg::OP_ADD: flags_q <= {sum == '0, sum_ovf, sum[15]};
				wisc_pkg::OP_SUB: flags_q <= {diff == '0, diff_ovf, diff[15]};
				wisc_pkg::OP_XOR, wisc_pkg::OP_SLL, wisc_pkg::OP_SRA, wisc_pkg::OP_ROR: begin
					flags_q[wisc_pkg::FLAG_Z] <= (result_o == '0);
				end
				default: ;
			endcase
		end
	end

	assign flags_o = flags_q;

endmodule

/* source/wisc_cpu.sv */
`timescale 1ns/1ns

module wisc_cpu (
	input  logic            clk,
	input  logic            arst_n_i,
	input  wisc_pkg::word_t imem_data_i,
	input  wisc_pkg::word_t dmem_rdata_i,
	output wisc_pkg::word_t imem_addr_o,
	output wisc_pkg::word_t dmem_addr_o,
	output wisc_pkg::word_t dmem_wdata_o,
	output logic            dmem_en_o,
	output logic            dmem_wr_o,
	output logic            hlt_o
);

	wisc_pkg::word_t  rdata1;
	wisc_pkg::word_t  rdata2;
	wisc_pkg::word_t  alu_result;
	wisc_pkg::word_t  alu_addr;
	wisc_pkg::word_t  pc_plus2;
	wisc_pkg::word_t  wdata;
	wisc_pkg::flags_t flags;
	logic hlt;

	wisc_ctrl_if ctrl_bus ();

	wisc_decode decode_inst (.instr_i(imem_data_i), .ctrl(ctrl_bus.decode), .hlt_o(hlt));

	wisc_regfile regfile_inst (.clk(clk), .arst_n_i(arst_n_i), .ctrl(ctrl_bus.regfile),
		.wdata_i(wdata), .rdata1_o(rdata1), .rdata2_o(rdata2));

	wisc_alu alu_inst (.clk(clk), .arst_n_i(arst_n_i), .ctrl(ctrl_bus.alu), .a_i(rdata1),
		.b_i(rdata2), .result_o(alu_result), .addr_o(alu_addr), .flags_o(flags));

	// BR jumps to the src1 register value.
	wisc_pc_unit pc_unit_inst (.clk(clk), .arst_n_i(arst_n_i), .ctrl(ctrl_bus.pc), .hlt_i(hlt),
		.flags_i(flags), .target_i(rdata1), .pc_o(imem_addr_o), .pc_plus2_o(pc_plus2));

	wisc_writeback writeback_inst (.ctrl(ctrl_bus.wb), .alu_i(alu_result), .mem_i(dmem_rdata_i),
		.pc_plus2_i(pc_plus2), .merge_base_i(rdata1), .wdata_o(wdata));

	assign dmem_addr_o  = alu_addr;
	assign dmem_wdata_o = rdata2; // SW routes its data register onto src2.
	assign dmem_en_o    = ctrl_bus.mem_en;
	assign dmem_wr_o    = ctrl_bus.mem_wr;
	assign hlt_o        = hlt;

endmodule

/* source/wisc_ctrl_if.sv */
`timescale 1ns/1ns

interface wisc_ctrl_if;

	wisc_pkg::reg_addr_t            src1;
	wisc_pkg::reg_addr_t            src2;
	wisc_pkg::reg_addr_t            dst;
	logic                           reg_we;
	wisc_pkg::word_t                imm; // already sign extended.
	logic [wisc_pkg::BYTE_W-1:0]    byte_imm;
	logic [wisc_pkg::BR_OFF_W-1:0]  br_off;
	wisc_pkg::opcode_e              op;
	logic                           use_imm;
	wisc_pkg::cond_e                cond;
	logic                           is_branch;
	logic                           is_branch_reg;
	logic                           mem_en;
	logic                           mem_wr;
	wisc_pkg::wb_sel_e              wb_sel;

	modport decode (output src1, src2, dst, reg_we, imm, byte_imm, br_off, op, use_imm,
		cond, is_branch, is_branch_reg, mem_en, mem_wr, wb_sel);
	modport regfile (input src1, src2, dst, reg_we);
	modport alu (input op, use_imm, imm);
	modport pc (input cond, is_branch, is_branch_reg, br_off);
	modport wb (input wb_sel, byte_imm, op);

endinterface

/* source/wisc_decode.sv */
`timescale 1ns/1ns

module wisc_decode (
	input  wisc_pkg::word_t instr_i,
	wisc_ctrl_if.decode     ctrl,
	output logic            hlt_o
);

	wisc_pkg::opcode_e opcode;

	assign opcode = wisc_pkg::opcode_e'(instr_i[wisc_pkg::OPC_LSB +: wisc_pkg::OPC_W]);

	assign ctrl.op       = opcode;
	assign ctrl.dst      = instr_i[wisc_pkg::RD_LSB +: wisc_pkg::REG_AW];
	assign ctrl.imm      = {{(wisc_pkg::WORD_W-wisc_pkg::IMM_W){instr_i[wisc_pkg::IMM_W-1]}},
		instr_i[wisc_pkg::IMM_W-1:0]};
	assign ctrl.byte_imm = instr_i[wisc_pkg::BYTE_W-1:0];
	assign ctrl.br_off   = instr_i[wisc_pkg::BR_OFF_W-1:0];
	assign ctrl.cond     = wisc_pkg::cond_e'(instr_i[wisc_pkg::CC_LSB +: 3]);
	assign hlt_o         = (opcode == wisc_pkg::OP_HLT);

	always_comb begin
		ctrl.src1          = instr_i[wisc_pkg::RS_LSB +: wisc_pkg::REG_AW];
		ctrl.src2          = instr_i[wisc_pkg::RT_LSB +: wisc_pkg::REG_AW];
		ctrl.reg_we        = 1'b0;
		ctrl.use_imm       = 1'b0;
		ctrl.mem_en        = 1'b0;
		ctrl.mem_wr        = 1'b0;
		ctrl.is_branch     = 1'b0;
		ctrl.is_branch_reg = 1'b0;
		ctrl.wb_sel        = wisc_pkg::WB_ALU;
		case (opcode)
			wisc_pkg::OP_ADD, wisc_pkg::OP_SUB, wisc_pkg::OP_XOR,
			wisc_pkg::OP_RED, wisc_pkg::OP_PADDSB: begin
				ctrl.reg_we = 1'b1;
			end
			wisc_pkg::OP_SLL, wisc_pkg::OP_SRA, wisc_pkg::OP_ROR: begin
				ctrl.reg_we  = 1'b1;
				ctrl.use_imm = 1'b1;
			end
			wisc_pkg::OP_LW: begin
				ctrl.reg_we  = 1'b1;
				ctrl.use_imm = 1'b1;
				ctrl.mem_en  = 1'b1;
				ctrl.wb_sel  = wisc_pkg::WB_MEM;
			end
			wisc_pkg::OP_SW: begin
				ctrl.use_imm = 1'b1;
				ctrl.mem_en  = 1'b1;
				ctrl.mem_wr  = 1'b1;
				ctrl.src2    = instr_i[wisc_pkg::RD_LSB +: wisc_pkg::REG_AW]; // store data register.
			end
			wisc_pkg::OP_LHB, wisc_pkg::OP_LLB: begin
				ctrl.reg_we = 1'b1;
				ctrl.src1   = instr_i[wisc_pkg::RD_LSB +: wisc_pkg::REG_AW]; // merge base is dst.
				ctrl.wb_sel = wisc_pkg::WB_BYTE;
			end
			wisc_pkg::OP_B:   ctrl.is_branch = 1'b1;
			wisc_pkg::OP_BR:  ctrl.is_branch_reg = 1'b1;
			wisc_pkg::OP_PCS: begin
				ctrl.reg_we = 1'b1;
				ctrl.wb_sel = wisc_pkg::WB_PC_NEXT;
			end
			default: ; // HLT only stops the PC.
		endcase
	end

endmodule

/* source/wisc_pc_unit.sv */
`timescale 1ns/1ns

module wisc_pc_unit (
	input  logic             clk,
	input  logic             arst_n_i,
	wisc_ctrl_if.pc          ctrl,
	input  logic             hlt_i,
	input  wisc_pkg::flags_t flags_i,
	input  wisc_pkg::word_t  target_i,
	output wisc_pkg::word_t  pc_o,
	output wisc_pkg::word_t  pc_plus2_o
);

	wisc_pkg::word_t pc_q;
	wisc_pkg::word_t pc_next;
	wisc_pkg::word_t br_target;
	logic flag_z;
	logic flag_v;
	logic flag_n;
	logic taken;

	assign flag_z = flags_i[wisc_pkg::FLAG_Z];
	assign flag_v = flags_i[wisc_pkg::FLAG_V];
	assign flag_n = flags_i[wisc_pkg::FLAG_N];

	always_comb begin
		case (ctrl.cond)
			wisc_pkg::CC_NE: taken = !flag_z;
			wisc_pkg::CC_EQ: taken = flag_z;
			wisc_pkg::CC_GT: taken = !flag_z && !flag_n;
			wisc_pkg::CC_LT: taken = flag_n;
			wisc_pkg::CC_GE: taken = flag_z || !flag_n;
			wisc_pkg::CC_LE: taken = flag_z || flag_n;
			wisc_pkg::CC_OV: taken = flag_v;
			default:         taken = 1'b1;
		endcase
	end

	assign pc_plus2_o = pc_q + 16'd2;
	assign br_target  = pc_plus2_o + {{(wisc_pkg::WORD_W-wisc_pkg::BR_OFF_W-1){ctrl.br_off[8]}},
		ctrl.br_off, 1'b0};

	always_comb begin
		if (hlt_i) begin
			pc_next = pc_q; // halted core refetches the same word.
		end else if (ctrl.is_branch && taken) begin
			pc_next = br_target;
		end else if (ctrl.is_branch_reg && taken) begin
			pc_next = target_i;
		end else begin
			pc_next = pc_plus2_o;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) pc_q <= '0;
		else           pc_q <= pc_next;
	end

	assign pc_o = pc_q;

endmodule

/* source/wisc_pkg.sv */
package wisc_pkg;

	localparam int WORD_W   = 16;
	localparam int NUM_REGS = 16;
	localparam int REG_AW   = $clog2(NUM_REGS);

	// instruction field widths and positions.
	localparam int OPC_W    = 4;
	localparam int IMM_W    = 4;
	localparam int BYTE_W   = 8;
	localparam int BR_OFF_W = 9;
	localparam int OPC_LSB  = 12;
	localparam int RD_LSB   = 8;
	localparam int RS_LSB   = 4;
	localparam int RT_LSB   = 0;
	localparam int CC_LSB   = 9;

	localparam int FLAG_Z = 2; // flag vector is ordered Z, V, N from the top.
	localparam int FLAG_V = 1;
	localparam int FLAG_N = 0;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_AW-1:0] reg_addr_t;
	typedef logic [2:0]        flags_t;

	typedef enum logic [OPC_W-1:0] {
		OP_ADD, OP_SUB, OP_XOR, OP_RED, OP_SLL, OP_SRA, OP_ROR, OP_PADDSB,
		OP_LW, OP_SW, OP_LHB, OP_LLB, OP_B, OP_BR, OP_PCS, OP_HLT
	} opcode_e;

	typedef enum logic [2:0] {
		CC_NE, CC_EQ, CC_GT, CC_LT, CC_GE, CC_LE, CC_OV, CC_UN
	} cond_e;

	typedef enum logic [1:0] {
		WB_ALU, WB_MEM, WB_PC_NEXT, WB_BYTE
	} wb_sel_e;

endpackage

/* source/wisc_regfile.sv */
`timescale 1ns/1ns

module wisc_regfile (
	input  logic            clk,
	input  logic            arst_n_i,
	wisc_ctrl_if.regfile    ctrl,
	input  wisc_pkg::word_t wdata_i,
	output wisc_pkg::word_t rdata1_o,
	output wisc_pkg::word_t rdata2_o
);

	wisc_pkg::word_t regs [wisc_pkg::NUM_REGS];

	logic wr_en;

	assign wr_en = ctrl.reg_we && (ctrl.dst != '0); // R0 is never written.

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			regs <= '{default: '0};
		end else if (wr_en) begin
			regs[ctrl.dst] <= wdata_i;
		end
	end

	// reads see the old value in the cycle that writes the same register.
	always_comb begin
		if (ctrl.src1 == '0) begin
			rdata1_o = '0;
		end else begin
			rdata1_o = regs[ctrl.src1];
		end
	end

	always_comb begin
		if (ctrl.src2 == '0) begin
			rdata2_o = '0;
		end else begin
			rdata2_o = regs[ctrl.src2];
		end
	end

endmodule

/* source/wisc_writeback.sv */
`timescale 1ns/1ns

module wisc_writeback (
	wisc_ctrl_if.wb         ctrl,
	input  wisc_pkg::word_t alu_i,
	input  wisc_pkg::word_t mem_i,
	input  wisc_pkg::word_t pc_plus2_i,
	input  wisc_pkg::word_t merge_base_i,
	output wisc_pkg::word_t wdata_o
);

	localparam int BW = wisc_pkg::BYTE_W;

	wisc_pkg::word_t byte_merge;

	// LHB replaces the upper byte and LLB the lower one.
	always_comb begin
		if (ctrl.op == wisc_pkg::OP_LHB) begin
			byte_merge = {ctrl.byte_imm, merge_base_i[BW-1:0]};
		end else begin
			byte_merge = {merge_base_i[wisc_pkg::WORD_W-1:BW], ctrl.byte_imm};
		end
	end

	always_comb begin
		case (ctrl.wb_sel)
			wisc_pkg::WB_MEM:     wdata_o = mem_i;
			wisc_pkg::WB_PC_NEXT: wdata_o = pc_plus2_i;
			wisc_pkg::WB_BYTE:    wdata_o = byte_merge;
			default:              wdata_o = alu_i;
		endcase
	end

endmodule

/* test/wisc_cpu_checker.sv */
`timescale 1ns/1ns

module wisc_cpu_checker (
	input logic            clk,
	input logic            arst_n_i,
	input wisc_pkg::word_t imem_addr_i,
	input logic            dmem_en_i,
	input logic            dmem_wr_i,
	input logic            hlt_i
);

	wr_needs_en: assert property (@(posedge clk) disable iff (!arst_n_i)
		dmem_wr_i |-> dmem_en_i)
		else $error("store strobe seen without the memory enable");

	// a halted core keeps fetching the same word.
	hlt_holds_pc: assert property (@(posedge clk) disable iff (!arst_n_i)
		hlt_i |=> $stable(imem_addr_i))
		else $error("fetch address moved while the core was halted");

	pc_even: assert property (@(posedge clk) disable iff (!arst_n_i)
		imem_addr_i[0] == 1'b0)
		else $error("fetch address is odd");

	en_known: assert property (@(posedge clk) disable iff (!arst_n_i)
		!$isunknown(dmem_en_i))
		else $error("memory enable is unknown after reset");

endmodule

/* test/wisc_cpu_tb.sv */
`timescale 1ns/1ns

module wisc_cpu_tb;

	localparam int RUN_CYCLES  = 600;
	localparam int HALT_CYCLES = 5;
	localparam int MAX_CYCLES  = 2 + RUN_CYCLES + HALT_CYCLES + 33; // reset, run, halt and slack.

	logic             clk;
	logic             arst_n_i;
	wisc_pkg::word_t  imem_data_i;
	wisc_pkg::word_t  dmem_rdata_i;
	wisc_pkg::word_t  imem_addr_o;
	wisc_pkg::word_t  dmem_addr_o;
	wisc_pkg::word_t  dmem_wdata_o;
	logic             dmem_en_o;
	logic             dmem_wr_o;
	logic             hlt_o;
	wisc_pkg::word_t  prog [256];
	wisc_pkg::word_t  dmem [256];
	wisc_pkg::word_t  m_mem [256];
	wisc_pkg::word_t  m_regs [16];
	wisc_pkg::word_t  m_pc;
	wisc_pkg::flags_t m_flags;
	wisc_pkg::word_t  exp_addr;
	wisc_pkg::word_t  exp_wdata;
	logic             exp_en;
	logic             exp_wr;
	logic [15:0]      lfsr = 16'd64143;
	int               cycle_cnt = 0;
	int               check_cnt = 0;
	int               mismatch_cnt = 0;

	wisc_cpu wisc_cpu_inst (.clk(clk), .arst_n_i(arst_n_i), .imem_data_i(imem_data_i),
		.dmem_rdata_i(dmem_rdata_i), .imem_addr_o(imem_addr_o), .dmem_addr_o(dmem_addr_o),
		.dmem_wdata_o(dmem_wdata_o), .dmem_en_o(dmem_en_o), .dmem_wr_o(dmem_wr_o), .hlt_o(hlt_o));

	bind wisc_cpu wisc_cpu_checker checker_inst (.clk(clk), .arst_n_i(arst_n_i),
		.imem_addr_i(imem_addr_o), .dmem_en_i(dmem_en_o), .dmem_wr_i(dmem_wr_o), .hlt_i(hlt_o));

	// taps 16, 14, 13, 11 give a maximal length sequence.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic wisc_pkg::word_t rand_word();
		wisc_pkg::word_t v;
		v = '0;
		for (int i = 0; i < 16; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	// R15 is written only by PCS, so BR through R15 always lands on an even address.
	function automatic wisc_pkg::word_t shape_instr(input wisc_pkg::word_t w);
		if (w[15:12] == 4'hF) w[15:12] = 4'h0; // no HLT in the random program.
		case (w[15:12])
			4'hC: w[8:3] = '0; // short forward branch.
			4'hD: w[7:4] = 4'hF;
			4'hE: w[11:8] = 4'hF;
			4'h9: ;
			default: if (w[11:8] == 4'hF) w[11:8] = 4'hE;
		endcase
		return w;
	endfunction

	function automatic logic [3:0] sat_nibble(input logic [3:0] x, input logic [3:0] y);
		int t;
		t = int'($signed(x)) + int'($signed(y));
		if (t > 7) t = 7;
		if (t < -8) t = -8;
		return t[3:0];
	endfunction

	function automatic logic cond_true(input logic [2:0] cc, input wisc_pkg::flags_t f);
		case (wisc_pkg::cond_e'(cc))
			wisc_pkg::CC_NE: return !f[2];
			wisc_pkg::CC_EQ: return f[2];
			wisc_pkg::CC_GT: return !f[2] && !f[0];
			wisc_pkg::CC_LT: return f[0];
			wisc_pkg::CC_GE: return f[2] || !f[0];
			wisc_pkg::CC_LE: return f[2] || f[0];
			wisc_pkg::CC_OV: return f[1];
			default:         return 1'b1;
		endcase
	endfunction

	task automatic check_value(input string what, input wisc_pkg::word_t got,
		input wisc_pkg::word_t exp);
		check_cnt++;
		assert (got === exp) else begin
			mismatch_cnt++;
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic model_step(input wisc_pkg::word_t instr);
		wisc_pkg::opcode_e op;
		wisc_pkg::word_t   a;
		wisc_pkg::word_t   b;
		wisc_pkg::word_t   imm;
		wisc_pkg::word_t   pc2;
		wisc_pkg::word_t   next_pc;
		wisc_pkg::word_t   res;
		logic [3:0]        rd;
		int                s;
		int                sh;
		op = wisc_pkg::opcode_e'(instr[15:12]);
		rd = instr[11:8];
		a = m_regs[instr[7:4]];
		b = m_regs[instr[3:0]];
		imm = {{12{instr[3]}}, instr[3:0]};
		sh = int'(instr[3:0]);
		pc2 = m_pc + 16'd2;
		next_pc = pc2;
		res = '0;
		exp_en = (op == wisc_pkg::OP_LW) || (op == wisc_pkg::OP_SW);
		exp_wr = (op == wisc_pkg::OP_SW);
		exp_addr = (a & 16'hFFFE) + (imm << 1);
		exp_wdata = m_regs[rd];
		case (op)
			wisc_pkg::OP_ADD, wisc_pkg::OP_SUB: begin
				s = (op == wisc_pkg::OP_ADD) ? int'($signed(a)) + int'($signed(b))
					: int'($signed(a)) - int'($signed(b));
				res = s[15:0];
				m_flags = {res == 16'd0, s > 32767 || s < -32768, res[15]};
			end
			wisc_pkg::OP_XOR: res = a ^ b;
			wisc_pkg::OP_RED: begin
				s = int'($signed(a[15:8])) + int'($signed(a[7:0])) + int'($signed(b[15:8]))
					+ int'($signed(b[7:0]));
				res = s[15:0];
			end
			wisc_pkg::OP_SLL: res = a << sh;
			wisc_pkg::OP_SRA: res = $signed(a) >>> sh;
			wisc_pkg::OP_ROR: begin
				res = a;
				repeat (sh) res = {res[0], res[15:1]};
			end
			wisc_pkg::OP_PADDSB: res = {sat_nibble(a[15:12], b[15:12]), sat_nibble(a[11:8], b[11:8]),
				sat_nibble(a[7:4], b[7:4]), sat_nibble(a[3:0], b[3:0])};
			wisc_pkg::OP_LW:  res = m_mem[exp_addr[8:1]];
			wisc_pkg::OP_SW:  m_mem[exp_addr[8:1]] = m_regs[rd];
			wisc_pkg::OP_LHB: res = {instr[7:0], m_regs[rd][7:0]};
			wisc_pkg::OP_LLB: res = {m_regs[rd][15:8], instr[7:0]};
			wisc_pkg::OP_B: begin
				if (cond_true(instr[11:9], m_flags))
					next_pc = pc2 + 16'(2 * int'($signed(instr[8:0])));
			end
			wisc_pkg::OP_BR:  if (cond_true(instr[11:9], m_flags)) next_pc = a;
			wisc_pkg::OP_PCS: res = pc2;
			default:          next_pc = m_pc;
		endcase
		if (op inside {wisc_pkg::OP_XOR, wisc_pkg::OP_SLL, wisc_pkg::OP_SRA, wisc_pkg::OP_ROR})
			m_flags[2] = (res == 16'd0);
		if (((op <= wisc_pkg::OP_LLB && op != wisc_pkg::OP_SW) || op == wisc_pkg::OP_PCS)
			&& rd != 4'd0) m_regs[rd] = res;
		m_pc = next_pc;
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial begin
		wisc_pkg::word_t instr;
		wisc_pkg::word_t halt_pc;
		arst_n_i = 1'b0;
		imem_data_i = '0;
		dmem_rdata_i = '0;
		m_regs = '{default: '0};
		m_flags = '0;
		m_pc = '0;
		halt_pc = '0;
		for (int k = 0; k < 256; k++) prog[k[7:0]] = shape_instr(rand_word());
		for (int k = 0; k < 256; k++) begin
			dmem[k[7:0]] = rand_word();
			m_mem[k[7:0]] = dmem[k[7:0]];
		end
		repeat (2) @(posedge clk);
		#5;
		arst_n_i = 1'b1;
		for (int cyc = 0; cyc < RUN_CYCLES + HALT_CYCLES; cyc++) begin
			if (cyc == RUN_CYCLES) begin
				for (int k = 0; k < 256; k++) prog[k[7:0]] = 16'hF000;
				halt_pc = m_pc;
			end
			imem_data_i = prog[imem_addr_o[8:1]];
			#5;
			dmem_rdata_i = dmem[dmem_addr_o[8:1]]; // address depends on the fetched word.
			#10;
			instr = prog[m_pc[8:1]];
			check_value("imem_addr_o", imem_addr_o, m_pc);
			check_value("hlt_o", 16'(hlt_o), 16'(instr[15:12] == 4'hF));
			model_step(instr);
			check_value("dmem_en_o", 16'(dmem_en_o), 16'(exp_en));
			check_value("dmem_wr_o", 16'(dmem_wr_o), 16'(exp_wr));
			if (exp_en) check_value("dmem_addr_o", dmem_addr_o, exp_addr);
			if (exp_wr) check_value("dmem_wdata_o", dmem_wdata_o, exp_wdata);
			if (cyc >= RUN_CYCLES) check_value("halted imem_addr_o", imem_addr_o, halt_pc);
			if (dmem_en_o === 1'b1 && dmem_wr_o === 1'b1) dmem[dmem_addr_o[8:1]] = dmem_wdata_o;
			@(posedge clk);
			#5;
		end
		$display("checks: %0d, mismatches: %0d", check_cnt, mismatch_cnt);
		if (mismatch_cnt == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* wisc_cpu.f */
source/wisc_pkg.sv
source/wisc_ctrl_if.sv
source/wisc_decode.sv
source/wisc_regfile.sv
source/wisc_alu.sv
source/wisc_pc_unit.sv
source/wisc_writeback.sv
source/wisc_cpu.sv
test/wisc_cpu_checker.sv
test/wisc_cpu_tb.sv
